/* rp_pkg.sv */
/*
  Shared widths, channel count, calibration register map and sample types
  for the two-channel analog front-end. Modules refer to the items here
  through scoped names.
*/

package rp_pkg;

  ///////////////////////////////
  // sizes
  ///////////////////////////////

  // channels per direction, ADC and DAC alike
  localparam int CHN     = 2;
  localparam int SMP_DW  = 14;
  localparam int GAIN_DW = 16;

  // gain is fixed point, 2**GAIN_SHIFT is unity
  localparam int GAIN_SHIFT = 14;
  localparam logic [GAIN_DW-1:0] GAIN_UNITY = 16'h4000;

  // full product and post-shift sum widths
  localparam int PROD_DW = SMP_DW + GAIN_DW;
  localparam int SUM_DW  = PROD_DW - GAIN_SHIFT + 1;

  // saturation limits of a signed sample
  localparam int SMP_MAX = 2**(SMP_DW-1) - 1;
  localparam int SMP_MIN = -(2**(SMP_DW-1));

  ///////////////////////////////
  // calibration register map
  ///////////////////////////////

  localparam int CFG_AW = 3;
  localparam int CFG_NR = 2**CFG_AW;
  // 1 = DAC, 0 = ADC
  localparam int CFG_DAC_BIT  = 2;
  // channel index
  localparam int CFG_CHN_BIT  = 1;
  // 1 = offset, 0 = gain
  localparam int CFG_OFFS_BIT = 0;

  ///////////////////////////////
  // types
  ///////////////////////////////

  typedef logic signed [SMP_DW-1:0]  sample_t;
  typedef logic signed [GAIN_DW-1:0] gain_t;
  typedef logic signed [SMP_DW-1:0]  offset_t;
  typedef logic        [SMP_DW-1:0]  raw_t;
  typedef logic        [CFG_AW-1:0]  cfg_addr_t;

  // converter code <-> signed sample, same bit operation both ways
  // msb kept, the rest inverted (negative slope on the converter side)
  function automatic logic [SMP_DW-1:0] flip_low(logic [SMP_DW-1:0] w);
    return {w[SMP_DW-1], ~w[SMP_DW-2:0]};
  endfunction

endpackage

/* calib_regs.sv */
/*
  Calibration register bank. Holds one gain and one offset per ADC and
  DAC channel, loaded by a single-cycle write strobe with address and data.
  Gains come out of reset at unity, offsets at zero.
*/

`timescale 1ns/1ps

module calib_regs (
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  // write port
  input  logic                                   cfg_we_i,
  input  rp_pkg::cfg_addr_t                      cfg_addr_i,
  input  rp_pkg::gain_t                          cfg_wdata_i,
  // ADC calibration
  output rp_pkg::gain_t   [rp_pkg::CHN-1:0]      adc_gain_o,
  output rp_pkg::offset_t [rp_pkg::CHN-1:0]      adc_offs_o,
  // DAC calibration
  output rp_pkg::gain_t   [rp_pkg::CHN-1:0]      dac_gain_o,
  output rp_pkg::offset_t [rp_pkg::CHN-1:0]      dac_offs_o
);

  ///////////////////////////////
  // address decode
  ///////////////////////////////

  // one-hot register select, all zero without a strobe
  logic [rp_pkg::CFG_NR-1:0] cfg_sel;
  // offset takes only the low sample bits of the data word
  rp_pkg::offset_t           cfg_offs;

  // register address from its three map fields
  function automatic int reg_addr(logic dac, int ch, logic offs);
    return (int'(dac) << rp_pkg::CFG_DAC_BIT) |
           (ch << rp_pkg::CFG_CHN_BIT) |
           (int'(offs) << rp_pkg::CFG_OFFS_BIT);
  endfunction

  assign cfg_sel  = cfg_we_i ? (rp_pkg::CFG_NR'(1) << cfg_addr_i) : '0;
  assign cfg_offs = rp_pkg::offset_t'(cfg_wdata_i[rp_pkg::SMP_DW-1:0]);

  ///////////////////////////////
  // registers
  ///////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int ch = 0; ch < rp_pkg::CHN; ch++) begin
        adc_gain_o[ch] <= rp_pkg::GAIN_UNITY;
        adc_offs_o[ch] <= '0;
        dac_gain_o[ch] <= rp_pkg::GAIN_UNITY;
        dac_offs_o[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < rp_pkg::CHN; ch++) begin
        // ADC side, bit 2 low
        if (cfg_sel[reg_addr(1'b0, ch, 1'b0)]) begin
          adc_gain_o[ch] <= cfg_wdata_i;
        end
        if (cfg_sel[reg_addr(1'b0, ch, 1'b1)]) begin
          adc_offs_o[ch] <= cfg_offs;
        end
        // DAC side, bit 2 high
        if (cfg_sel[reg_addr(1'b1, ch, 1'b0)]) begin
          dac_gain_o[ch] <= cfg_wdata_i;
        end
        if (cfg_sel[reg_addr(1'b1, ch, 1'b1)]) begin
          dac_offs_o[ch] <= cfg_offs;
        end
      end
    end
  end

endmodule

/* adc_decode.sv */
/*
  ADC input stage for one channel. Registers the raw converter word as a
  signed sample and, in digital loopback, hands on the calibrated DAC
  sample of the same channel instead.
*/

`timescale 1ns/1ps

module adc_decode (
  input  logic            adc_clk,
  input  logic            top_rst,
  // raw converter code
  input  rp_pkg::raw_t    adc_dat_i,
  // loopback select and source
  input  logic            digital_loop_i,
  input  rp_pkg::sample_t loop_dat_i,
  // decoded sample towards calibration
  output rp_pkg::sample_t adc_smp_o
);

  ///////////////////////////////
  // input register
  ///////////////////////////////

  // decoded sample, one cycle after the pin
  rp_pkg::sample_t adc_smp_q;

  // sign bit stays, magnitude bits are inverted by the converter
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_smp_q <= '0;
    end else begin
      adc_smp_q <= rp_pkg::sample_t'(rp_pkg::flip_low(adc_dat_i));
    end
  end

  ///////////////////////////////
  // loopback mux
  ///////////////////////////////

  // loop source is already registered in the DAC calibration,
  // so no extra stage here
  assign adc_smp_o = digital_loop_i ? loop_dat_i : adc_smp_q;

endmodule

/* linear_calib.sv */
/*
  Gain and offset calibration for one sample stream. Two pipeline stages:
  signed multiply first, then arithmetic shift, offset add and clamp to the
  sample range. A new sample is accepted on every cycle.
*/

`timescale 1ns/1ps

module linear_calib (
  input  logic            adc_clk,
  input  logic            top_rst,
  // sample in
  input  rp_pkg::sample_t smp_i,
  // calibration words
  input  rp_pkg::gain_t   gain_i,
  input  rp_pkg::offset_t offs_i,
  // calibrated sample out
  output rp_pkg::sample_t smp_o
);

  ///////////////////////////////
  // stage 1, multiply
  ///////////////////////////////

  // full precision product
  logic signed [rp_pkg::PROD_DW-1:0] prod_q;

  // operands sign extended to product width before the multiply
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
    end else begin
      prod_q <= smp_i * gain_i;
    end
  end

  ///////////////////////////////
  // stage 2, shift/add/clamp
  ///////////////////////////////

  logic signed [rp_pkg::SUM_DW-1:0] prod_shr;
  logic signed [rp_pkg::SUM_DW-1:0] offs_ext;
  logic signed [rp_pkg::SUM_DW-1:0] sum;
  rp_pkg::sample_t                  sat;
  rp_pkg::sample_t                  smp_q;

  // drop fraction bits, upper bits are only sign copies
  assign prod_shr = rp_pkg::SUM_DW'(prod_q >>> rp_pkg::GAIN_SHIFT);
  // sign extended offset
  assign offs_ext = offs_i;
  // one spare bit, this add cannot wrap
  assign sum      = prod_shr + offs_ext;

  // clamp to the signed sample range
  always_comb begin
    if (sum > rp_pkg::SMP_MAX) begin
      sat = rp_pkg::sample_t'(rp_pkg::SMP_MAX);
    end else if (sum < rp_pkg::SMP_MIN) begin
      sat = rp_pkg::sample_t'(rp_pkg::SMP_MIN);
    end else begin
      sat = rp_pkg::sample_t'(sum);
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_q <= '0;
    end else begin
      smp_q <= sat;
    end
  end

  assign smp_o = smp_q;

endmodule

/* dac_encode.sv */
/*
  DAC output register for one channel. Turns a signed sample into the
  converter's inverted offset-binary code, giving the negative slope the
  DAC expects. One cycle of latency.
*/

`timescale 1ns/1ps

module dac_encode (
  input  logic            adc_clk,
  input  logic            top_rst,
  // calibrated sample
  input  rp_pkg::sample_t smp_i,
  // code towards the DAC pins
  output rp_pkg::raw_t    dac_dat_o
);

  ///////////////////////////////
  // output register
  ///////////////////////////////

  // code of a zero sample, mid scale
  localparam rp_pkg::raw_t DAC_ZERO = rp_pkg::flip_low('0);

  rp_pkg::raw_t dac_dat_q;

  // after reset the DAC sits at mid scale, not at full negative swing
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_q <= DAC_ZERO;
    end else begin
      dac_dat_q <= rp_pkg::flip_low(smp_i);
    end
  end

  assign dac_dat_o = dac_dat_q;

endmodule

/* rp_frontend_top.sv */
/*
  Analog front-end of the two-channel board. Per channel the ADC word is
  decoded, optionally replaced by the DAC loopback, then calibrated to the
  oscilloscope output; generator samples are calibrated and encoded for the
  DAC. Calibration words come from one shared register bank.
*/

`timescale 1ns/1ps

module rp_frontend_top (
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // ADC raw codes and generator samples
  input  rp_pkg::raw_t    [rp_pkg::CHN-1:0]   adc_dat_i,
  input  rp_pkg::sample_t [rp_pkg::CHN-1:0]   asg_dat_i,
  // DAC to ADC loopback
  input  logic                                digital_loop_i,
  // calibration write port
  input  logic                                cfg_we_i,
  input  rp_pkg::cfg_addr_t                   cfg_addr_i,
  input  rp_pkg::gain_t                       cfg_wdata_i,
  // calibrated acquisition samples
  output rp_pkg::sample_t [rp_pkg::CHN-1:0]   osc_dat_o,
  // DAC codes, one word per channel
  output rp_pkg::raw_t    [rp_pkg::CHN-1:0]   dac_dat_o
);

  ///////////////////////////////
  // local signals
  ///////////////////////////////

  // ADC calibration words
  rp_pkg::gain_t   [rp_pkg::CHN-1:0] adc_gain;
  rp_pkg::offset_t [rp_pkg::CHN-1:0] adc_offs;
  // DAC calibration words
  rp_pkg::gain_t   [rp_pkg::CHN-1:0] dac_gain;
  rp_pkg::offset_t [rp_pkg::CHN-1:0] dac_offs;

  // decoded ADC samples, after the loopback mux
  rp_pkg::sample_t [rp_pkg::CHN-1:0] adc_smp;
  // calibrated DAC samples, also the loopback source
  rp_pkg::sample_t [rp_pkg::CHN-1:0] dac_cal;

  ///////////////////////////////
  // calibration registers
  ///////////////////////////////

  calib_regs calib_regs0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .adc_gain_o  (adc_gain),
    .adc_offs_o  (adc_offs),
    .dac_gain_o  (dac_gain),
    .dac_offs_o  (dac_offs)
  );

  ///////////////////////////////
  // per channel datapaths
  ///////////////////////////////

  for (genvar i = 0; i < rp_pkg::CHN; i++) begin : g_chn

    // ADC decode, 1 cycle (loopback passes straight through)
    adc_decode adc_decode0 (
      .adc_clk        (adc_clk),
      .top_rst        (top_rst),
      .adc_dat_i      (adc_dat_i[i]),
      .digital_loop_i (digital_loop_i),
      .loop_dat_i     (dac_cal[i]),
      .adc_smp_o      (adc_smp[i])
    );

    // ADC calibration, 2 cycles
    linear_calib linear_adc (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (adc_smp[i]),
      .gain_i  (adc_gain[i]),
      .offs_i  (adc_offs[i]),
      .smp_o   (osc_dat_o[i])
    );

    // DAC calibration, 2 cycles
    linear_calib linear_dac (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (asg_dat_i[i]),
      .gain_i  (dac_gain[i]),
      .offs_i  (dac_offs[i]),
      .smp_o   (dac_cal[i])
    );

    // DAC code register, 1 cycle
    dac_encode dac_encode0 (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .smp_i     (dac_cal[i]),
      .dac_dat_o (dac_dat_o[i])
    );

  end : g_chn

endmodule

/* tb_rp_frontend.sv */
/*
  Self-checking testbench for the two-channel analog front-end. Loads
  calibration writes and per-cycle samples with their expected outputs from
  the pattern file, drives them on the falling edge and compares the outputs
  once the pipeline latency has passed.
*/

`timescale 1ns/1ps

module tb_rp_frontend;

  localparam int CLK_PERIOD = 40;
  localparam int MAX_OPS    = 128;
  localparam int LAT_NORM   = 3;
  localparam int LAT_LOOP   = 4;
  localparam int SEED       = 32'h584e;

  logic                              adc_clk;
  logic                              top_rst;
  rp_pkg::raw_t    [rp_pkg::CHN-1:0] adc_dat;
  rp_pkg::sample_t [rp_pkg::CHN-1:0] asg_dat;
  logic                              digital_loop;
  logic                              cfg_we;
  rp_pkg::cfg_addr_t                 cfg_addr;
  rp_pkg::gain_t                     cfg_wdata;
  rp_pkg::sample_t [rp_pkg::CHN-1:0] osc_dat;
  rp_pkg::raw_t    [rp_pkg::CHN-1:0] dac_dat;

  // operations from the pattern file, W or S plus up to nine fields
  byte         op_kind [0:MAX_OPS-1];
  logic [15:0] op_fld  [0:MAX_OPS-1][0:8];
  int          n_ops;
  bit          loaded;

  // expected words, channel 1 in the upper half, with the cycle they fall due
  int          osc_due_q [$];
  logic [27:0] osc_exp_q [$];
  int          dac_due_q [$];
  logic [27:0] dac_exp_q [$];

  int cyc;
  int errors;
  int checks;

  rp_frontend_top dut0 (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat),
    .asg_dat_i      (asg_dat),
    .digital_loop_i (digital_loop),
    .cfg_we_i       (cfg_we),
    .cfg_addr_i     (cfg_addr),
    .cfg_wdata_i    (cfg_wdata),
    .osc_dat_o      (osc_dat),
    .dac_dat_o      (dac_dat)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD/2) adc_clk = ~adc_clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_word(input string name, input int ch,
                            input logic [13:0] exp, input logic [13:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s[%0d] expected %h actual %h", $time, name, ch, exp, act);
    end
  endtask

  // compare everything that falls due in the current cycle
  task automatic check_due();
    logic [27:0] e;
    while (osc_due_q.size() > 0 && osc_due_q[0] == cyc) begin
      e = osc_exp_q.pop_front();
      void'(osc_due_q.pop_front());
      check_word("osc_dat_o", 0, e[13:0], osc_dat[0]);
      check_word("osc_dat_o", 1, e[27:14], osc_dat[1]);
    end
    while (dac_due_q.size() > 0 && dac_due_q[0] == cyc) begin
      e = dac_exp_q.pop_front();
      void'(dac_due_q.pop_front());
      check_word("dac_dat_o", 0, e[13:0], dac_dat[0]);
      check_word("dac_dat_o", 1, e[27:14], dac_dat[1]);
    end
  endtask

  // falling edge, outputs settled since the last rising edge
  task automatic next_cycle();
    @(negedge adc_clk);
    cyc++;
    check_due();
    cfg_we = 1'b0;
  endtask

  // empty the pipeline with inputs held, then a short random idle gap
  task automatic drain();
    int gap;
    while (osc_due_q.size() > 0 || dac_due_q.size() > 0) begin
      next_cycle();
    end
    gap = $urandom % 4;
    repeat (gap) begin
      next_cycle();
    end
  endtask

  task automatic load_patterns(input int fd);
    int          c;
    int          n;
    logic [15:0] fv [0:8];
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "#") begin
        // comment up to end of line
        while (c != -1 && c != "\n") begin
          c = $fgetc(fd);
        end
      end else if (c == "W" || c == "S") begin
        for (int k = 0; k < 9; k++) begin
          fv[k] = '0;
        end
        if (c == "W") begin
          n = $fscanf(fd, "%h %h", fv[0], fv[1]);
        end else begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", fv[0], fv[1], fv[2],
                      fv[3], fv[4], fv[5], fv[6], fv[7], fv[8]);
        end
        if ((c == "W" && n != 2) || (c == "S" && n != 9) || n_ops >= MAX_OPS) begin
          $display("pattern line %0d is malformed or past the table size", n_ops + 1);
          errors++;
        end else begin
          op_kind[n_ops] = byte'(c);
          for (int k = 0; k < 9; k++) begin
            op_fld[n_ops][k] = fv[k];
          end
          n_ops++;
        end
      end else if (c > " ") begin
        $display("unknown operation code in the pattern file");
        errors++;
      end
      c = $fgetc(fd);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int fd;
    int lat;
    bit need_drain;
    adc_dat      = '0;
    asg_dat      = '0;
    digital_loop = 1'b0;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    top_rst      = 1'b1;
    errors       = 0;
    checks       = 0;
    cyc          = 0;
    n_ops        = 0;
    void'($urandom(SEED));
    fd = $fopen("rp_frontend_patterns.txt", "r");
    if (fd == 0) begin
      $display("the pattern file could not be opened");
      errors++;
    end else begin
      load_patterns(fd);
      $fclose(fd);
    end
    if (n_ops == 0) begin
      $display("no operations were loaded from the pattern file");
      errors++;
    end
    loaded = 1'b1;

    // five rising edges in reset, released on a falling edge
    repeat (5) @(posedge adc_clk);
    next_cycle();
    top_rst = 1'b0;
    for (int ch = 0; ch < rp_pkg::CHN; ch++) begin
      check_word("osc_dat_o", ch, 14'h0000, osc_dat[ch]);
      check_word("dac_dat_o", ch, 14'h1FFF, dac_dat[ch]);
    end

    for (int i = 0; i < n_ops; i++) begin
      // writes and loop changes must not hit samples still in flight
      if (op_kind[i] == "W") begin
        need_drain = (i > 0 && op_kind[i-1] == "S");
      end else begin
        need_drain = (op_fld[i][0][0] != digital_loop);
      end
      if (need_drain) begin
        drain();
      end
      next_cycle();
      if (op_kind[i] == "W") begin
        cfg_we    = 1'b1;
        cfg_addr  = op_fld[i][0][2:0];
        cfg_wdata = op_fld[i][1];
      end else begin
        digital_loop = op_fld[i][0][0];
        adc_dat[0]   = op_fld[i][1][13:0];
        adc_dat[1]   = op_fld[i][2][13:0];
        asg_dat[0]   = op_fld[i][3][13:0];
        asg_dat[1]   = op_fld[i][4][13:0];
        lat = digital_loop ? LAT_LOOP : LAT_NORM;
        osc_due_q.push_back(cyc + lat);
        osc_exp_q.push_back({op_fld[i][6][13:0], op_fld[i][5][13:0]});
        dac_due_q.push_back(cyc + LAT_NORM);
        dac_exp_q.push_back({op_fld[i][8][13:0], op_fld[i][7][13:0]});
      end
    end
    drain();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog, sized from the number of pattern operations
  initial begin
    wait (loaded);
    repeat (n_ops * 6 + 50) @(posedge adc_clk);
    $display("watchdog expired, run still busy after %0d clock cycles", n_ops * 6 + 50);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* rp_frontend_patterns.txt */
# W addr data   (calibration write, hex)
# S loop adc0 adc1 asg0 asg1 osc0 osc1 dac0 dac1   (one sample cycle, hex)
# unity calibration, raw codes straight through
S 0 0000 3FFF 0000 0000 1FFF 2000 1FFF 1FFF
S 0 2000 1FFF 0100 3F00 3FFF 0000 1EFF 20FF
S 0 1234 2ABC 1000 2000 0DCB 3543 0FFF 3FFF
S 0 0FFF 3000 1FFF 3FFF 1000 2FFF 0000 2000
# ADC ch0 gain one half, offset 100, ch1 untouched
W 0 2000
W 1 0064
S 0 0000 0000 0000 0000 1063 1FFF 1FFF 1FFF
S 0 2000 2000 0000 0000 0063 3FFF 1FFF 1FFF
S 0 3FFF 3FFF 0000 0000 3064 2000 1FFF 1FFF
S 0 1FF0 1FF0 0000 0000 006B 000F 1FFF 1FFF
# ADC ch1 gain minus one, offset minus 100 from the low 14 data bits
W 2 C000
W 3 FF9C
S 0 1FFF 0000 0000 0000 0064 2000 1FFF 1FFF
S 0 1FFF 3FFF 0000 0000 0064 1F9C 1FFF 1FFF
S 0 1FFF 1F00 0000 0000 0064 3E9D 1FFF 1FFF
# ADC ch0 gain near two, offset 8000, clamps high
W 0 7FFF
W 1 1F40
S 0 1FFF 1FFF 0000 0000 1F40 3F9C 1FFF 1FFF
S 0 1FF0 1FFF 0000 0000 1F5D 3F9C 1FFF 1FFF
S 0 1000 1FFF 0000 0000 1FFF 3F9C 1FFF 1FFF
# DAC ch0 gain 1.5 offset minus 10, DAC ch1 unity offset 50
W 4 6000
W 5 3FF6
W 7 0032
S 0 1FFF 1FFF 0100 0100 1F40 3F9C 1E89 1ECD
S 0 1FFF 1FFF 1800 1FF0 1F40 3F9C 0000 0000
S 0 1FFF 1FFF 2800 2000 1F40 3F9C 3FFF 3FCD
S 0 1FFF 1FFF 3FFF 3FFF 1F40 3F9C 200B 1FCE
# loopback, ADC ch0 back to unity, ADC ch1 gain one half
W 0 4000
W 1 0000
W 2 2000
W 3 0000
S 1 0000 0000 0100 0100 0176 0099 1E89 1ECD
S 1 0000 0000 3FFF 3FFF 3FF4 0018 200B 1FCE
S 1 0000 0000 1800 2000 1FFF 3019 0000 3FCD
S 1 0000 0000 0000 0000 3FF6 0019 2009 1FCD
# normal mode again
S 0 0000 0000 0000 0000 1FFF 0FFF 2009 1FCD

/* rp_frontend_top.f */
rp_pkg.sv
calib_regs.sv
adc_decode.sv
linear_calib.sv
dac_encode.sv
rp_frontend_top.sv
tb_rp_frontend.sv

/* run_sim.sh */
#!/bin/sh
# Builds the front-end testbench with Verilator and runs it.
# Exits non-zero unless the simulation output reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_rp_frontend \
  -f rp_frontend_top.f \
  -o tb_rp_frontend

out=$(./obj_dir/tb_rp_frontend)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1
